/* all.f */
src/opc_bus_pkg.sv
src/bus_decode.sv
src/word_ram.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_regs.sv
src/board_control.sv
src/opc_system.sv
sim/tb_opc_system_props.sv
sim/tb_opc_system.sv

/* Makefile */
SIM      := verilator
VFLAGS   := --binary --timing --assert --timescale 1ns/1ps
TOP      := tb_opc_system
FILELIST := all.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell cat $(FILELIST))
PASS_MSG := === PASS ===

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Output is shown and searched for the pass line
run: $(BIN)
	./$(BIN) | awk '{ print } /^$(PASS_MSG)$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

/* sim/tb_opc_system.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_opc_system
   import opc_bus_pkg::*;
();

   localparam int CLKSPEED     = 921600;
   localparam int BAUD         = 115200;
   localparam int RAMSIZE      = 12;
   localparam int COUNTER_BITS = 8;
   localparam int CLK_PERIOD   = 40;
   // Clocks per serial bit
   localparam int BIT_CYCLES   = CLKSPEED / BAUD;
   localparam int NUM_OPS      = 32;
   localparam int POLL_LIMIT   = 20;
   // Unmapped address where the bus parks between accesses
   localparam addr_t IDLE_ADDR = 16'h8000;
   localparam addr_t UART_DATA = UART_BASE + 16'd1;
   // RAM word that shares its low bits with the UART data register
   localparam addr_t SHADOW_ADDR = 16'h0e09;

   logic  clk;
   logic  reset_b;
   addr_t address;
   data_t dout;
   logic  rnw;
   data_t din;
   logic  rxd;
   logic  txd;
   logic  sw1_1;
   logic  sw1_2;
   logic  sw2_1;
   logic  sw2_2;
   logic  led1;
   logic  led2;
   logic  led3;
   logic  led4;

   // Bus operation table
   bit     op_read  [NUM_OPS];
   addr_t  op_addr  [NUM_OPS];
   data_t  op_wdata [NUM_OPS];
   data_t  op_exp   [NUM_OPS];
   // Expected RAM words, by low address bits
   data_t  ram_model [2**RAMSIZE];
   int     n_ops;
   integer seed;
   int     mismatches;
   int     failures;

   opc_system #(
      .CLKSPEED     (CLKSPEED),
      .BAUD         (BAUD),
      .RAMSIZE      (RAMSIZE),
      .COUNTER_BITS (COUNTER_BITS)
   ) dut0 (
      .clk     (clk),
      .reset_b (reset_b),
      .address (address),
      .dout    (dout),
      .rnw     (rnw),
      .din     (din),
      .rxd     (rxd),
      .txd     (txd),
      .sw1_1   (sw1_1),
      .sw1_2   (sw1_2),
      .sw2_1   (sw2_1),
      .sw2_2   (sw2_2),
      .led1    (led1),
      .led2    (led2),
      .led3    (led3),
      .led4    (led4)
   );

   initial
      clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic check_word(input string name, input data_t exp, input data_t act);
      if (act !== exp)
      begin
         mismatches++;
         $display("MISMATCH %s expected %h got %h", name, exp, act);
      end
   endtask

   task automatic check_byte(input string name, input byte_t exp, input byte_t act);
      if (act !== exp)
      begin
         mismatches++;
         $display("MISMATCH %s expected %h got %h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         mismatches++;
         $display("MISMATCH %s expected %h got %h", name, exp, act);
      end
   endtask

   task automatic report_failure(input string msg);
      failures++;
      $display("ERROR: %s", msg);
   endtask

   // One write cycle, then back to idle
   task automatic bus_write(input addr_t a, input data_t d);
      @(posedge clk);
      #2;
      address = a;
      dout    = d;
      rnw     = 1'b0;
      @(posedge clk);
      #2;
      address = IDLE_ADDR;
      rnw     = 1'b1;
   endtask

   // Sampled late in the cycle, after the RAM falling edge
   task automatic bus_read(input addr_t a, output data_t d);
      @(posedge clk);
      #2;
      address = a;
      rnw     = 1'b1;
      @(negedge clk);
      #10;
      d = din;
      @(posedge clk);
      #2;
      address = IDLE_ADDR;
   endtask

   task automatic add_op(input bit rd, input addr_t a, input data_t w, input data_t e);
      op_read[n_ops]  = rd;
      op_addr[n_ops]  = a;
      op_wdata[n_ops] = w;
      op_exp[n_ops]   = e;
      n_ops++;
   endtask

   task automatic build_table();
      int    i;
      addr_t a;
      data_t w;
      // Spread writes over the low 4K words
      for (i = 0; i < 8; i++)
      begin
         a = addr_t'(i * 'h1f3);
         w = data_t'($random(seed));
         ram_model[a[RAMSIZE-1:0]] = w;
         add_op(1'b0, a, w, '0);
      end
      for (i = 0; i < 8; i++)
         add_op(1'b1, addr_t'(i * 'h1f3), '0, ram_model[(i * 'h1f3) % 4096]);
      // Same words through the top mirror
      for (i = 0; i < 8; i++)
         add_op(1'b1, addr_t'('hf000 + i * 'h1f3), '0, ram_model[(i * 'h1f3) % 4096]);
      // Written high, read back low
      for (i = 0; i < 2; i++)
      begin
         a = addr_t'('hf123 + i * 'h400);
         w = data_t'($random(seed));
         ram_model[a[RAMSIZE-1:0]] = w;
         add_op(1'b0, a, w, '0);
         add_op(1'b1, a & 16'h0fff, '0, w);
      end
      // Gap between the mirrors
      add_op(1'b1, 16'h1000, '0, IDLE_DATA);
      add_op(1'b1, 16'h4a5c, '0, IDLE_DATA);
      add_op(1'b1, 16'h8000, '0, IDLE_DATA);
      add_op(1'b1, 16'hefff, '0, IDLE_DATA);
   endtask

   task automatic apply_table();
      int    i;
      data_t rd;
      for (i = 0; i < n_ops; i++)
      begin
         if (!op_read[i])
            bus_write(op_addr[i], op_wdata[i]);
         else
         begin
            bus_read(op_addr[i], rd);
            check_word($sformatf("din@%h", op_addr[i]), op_exp[i], rd);
         end
      end
   endtask

   // Start bit low, 8 data bits LSB first, stop bit high
   task automatic send_rx_frame(input byte_t b);
      int k;
      @(posedge clk);
      #2;
      rxd = 1'b0;
      for (k = 0; k < 8; k++)
      begin
         repeat (BIT_CYCLES) @(posedge clk);
         #2;
         rxd = b[k];
      end
      repeat (BIT_CYCLES) @(posedge clk);
      #2;
      rxd = 1'b1;
      repeat (BIT_CYCLES) @(posedge clk);
   endtask

   // Samples at bit centres timed from the start edge
   task automatic receive_tx_frame(output byte_t b);
      int    k;
      byte_t v;
      wait (txd == 1'b0);
      repeat (BIT_CYCLES / 2) @(negedge clk);
      check_bit("txd start bit", 1'b0, txd);
      for (k = 0; k < 8; k++)
      begin
         repeat (BIT_CYCLES) @(negedge clk);
         v[k] = txd;
      end
      repeat (BIT_CYCLES) @(negedge clk);
      check_bit("txd stop bit", 1'b1, txd);
      b = v;
   endtask

   task automatic wait_status(input int idx, input logic want, input string what);
      data_t st;
      int    tries;
      tries = 0;
      bus_read(UART_BASE, st);
      while (st[idx] !== want && tries < POLL_LIMIT)
      begin
         bus_read(UART_BASE, st);
         tries++;
      end
      if (st[idx] !== want)
         report_failure($sformatf("%s never reached %0d while polling status", what, want));
   endtask

   // Cycles between two toggles of led4
   task automatic measure_led4(output int n);
      logic last;
      @(negedge clk);
      last = led4;
      n = 0;
      while (led4 == last && n < 64)
      begin
         @(negedge clk);
         n++;
      end
      last = led4;
      n = 0;
      while (led4 == last && n < 64)
      begin
         @(negedge clk);
         n++;
      end
   endtask

   initial
   begin
      data_t rd;
      data_t keep;
      byte_t got;
      byte_t tx_byte;
      byte_t rx_byte;
      int    half;
      int    total;
      seed       = 72935;
      mismatches = 0;
      failures   = 0;
      n_ops      = 0;
      reset_b    = 1'b0;
      address    = IDLE_ADDR;
      dout       = '0;
      rnw        = 1'b1;
      rxd        = 1'b1;
      sw1_1      = 1'b0;
      sw1_2      = 1'b0;
      sw2_1      = 1'b0;
      sw2_2      = 1'b0;
      build_table();
      if (n_ops != NUM_OPS)
         report_failure("stimulus table length does not match its declared size");
      repeat (10) @(posedge clk);
      #2;
      reset_b = 1'b1;

      // Counter still zero and line idle
      @(negedge clk);
      check_bit("led1", 1'b0, led1);
      check_bit("led2", 1'b0, led2);
      check_bit("led3", 1'b0, led3);
      check_bit("led4", 1'b0, led4);
      check_bit("txd", 1'b1, txd);
      // Top counter bits are all still low here
      @(posedge clk);
      #2;
      sw1_1 = 1'b1;
      sw1_2 = 1'b1;
      sw2_1 = 1'b1;
      sw2_2 = 1'b1;
      @(negedge clk);
      check_bit("led1 forced", 1'b1, led1);
      check_bit("led2 forced", 1'b1, led2);
      check_bit("led3 forced", 1'b1, led3);
      check_bit("led4 forced", 1'b1, led4);
      @(posedge clk);
      #2;
      sw1_1 = 1'b0;
      sw1_2 = 1'b0;
      sw2_1 = 1'b0;
      sw2_2 = 1'b0;
      // Counter bit 4 flips every 16 clocks
      measure_led4(half);
      check_word("led4 half period", 16'd16, data_t'(half));

      apply_table();

      // RAM word under the UART data register
      keep    = data_t'($random(seed));
      tx_byte = byte_t'($random(seed));
      bus_write(SHADOW_ADDR, keep);
      fork
         receive_tx_frame(got);
         begin
            bus_write(UART_DATA, {8'hc3, tx_byte});
            bus_read(UART_BASE, rd);
            check_word("uart status while sending", 16'h0002, rd);
            // Dropped write must leave the frame on the line unchanged
            bus_write(UART_DATA, {8'h00, ~tx_byte});
         end
      join
      check_byte("txd frame", tx_byte, got);
      wait_status(UART_STATUS_TX_BUSY, 1'b0, "tx_busy");
      check_bit("txd after frame", 1'b1, txd);
      bus_read(SHADOW_ADDR, rd);
      check_word("ram word 0e09", keep, rd);

      // Receive path
      rx_byte = byte_t'($random(seed));
      send_rx_frame(rx_byte);
      wait_status(UART_STATUS_RX_FULL, 1'b1, "rx_full");
      bus_read(UART_DATA, rd);
      check_word("uart data", {8'h00, rx_byte}, rd);
      bus_read(UART_BASE, rd);
      check_word("uart status after data read", 16'h0000, rd);

      total = mismatches + failures + dut0.props0.prop_failures;
      $display("Checks done: %0d mismatches, %0d other errors, %0d assertion failures",
               mismatches, failures, dut0.props0.prop_failures);
      if (total == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

   // Limit covers the table, the serial frames and a fixed margin
   initial
   begin
      #((NUM_OPS * 4 + 60 * BIT_CYCLES + 2000) * CLK_PERIOD);
      $display("Timeout: the test did not reach its end within the time limit");
      $display("=== FAIL ===");
      $finish;
   end

endmodule

`default_nettype wire

/* sim/tb_opc_system_props.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_opc_system_props
   import opc_bus_pkg::*;
(
   input wire   clk,
   input wire   sys_reset_b,
   input wire   ram_cs_b,
   input wire   uart_cs_b,
   input wire   rnw,
   input addr_t address,
   input wire   txd,
   input wire   tx_busy,
   input wire   rx_full
);

   int prop_failures = 0;

   // One device per address
   cs_exclusive: assert property (@(posedge clk) !(!ram_cs_b && !uart_cs_b))
   else
   begin
      $error("RAM and UART selected together at address %h", address);
      prop_failures++;
   end

   // Line idles high between frames
   txd_idle_high: assert property (@(posedge clk) disable iff (!sys_reset_b)
      !tx_busy |-> txd)
   else
   begin
      $error("txd low while the transmitter is idle");
      prop_failures++;
   end

   // Only a data register read empties the receive buffer
   rx_full_cleared_by_read: assert property (@(posedge clk) disable iff (!sys_reset_b)
      $fell(rx_full) |-> $past(!uart_cs_b && rnw && address[0]))
   else
   begin
      $error("rx_full cleared without a data read");
      prop_failures++;
   end

endmodule

bind opc_system tb_opc_system_props props0 (
   .clk         (clk),
   .sys_reset_b (sys_reset_b),
   .ram_cs_b    (ram_cs_b),
   .uart_cs_b   (uart_cs_b),
   .rnw         (rnw),
   .address     (address),
   .txd         (txd),
   .tx_busy     (uart_regs0.tx_busy),
   .rx_full     (uart_regs0.rx_full)
);

`default_nettype wire

/* src/opc_system.sv */
`timescale 1ns/1ps
`default_nettype none

module opc_system
   import opc_bus_pkg::*;
#(
   parameter int CLKSPEED     = 40000000,
   parameter int BAUD         = 115200,
   parameter int RAMSIZE      = 12,
   parameter int COUNTER_BITS = 24
)
(
   input  wire   clk,
   input  wire   reset_b,
   input  addr_t address,
   input  data_t dout,
   input  wire   rnw,
   output data_t din,
   input  wire   rxd,
   output logic  txd,
   input  wire   sw1_1,
   input  wire   sw1_2,
   input  wire   sw2_1,
   input  wire   sw2_2,
   output logic  led1,
   output logic  led2,
   output logic  led3,
   output logic  led4
);

   logic  sys_reset_b;
   logic  ram_cs_b;
   logic  uart_cs_b;
   data_t ram_dout;
   data_t uart_dout;

   // Registered reset and heartbeat LEDs
   board_control #(
      .COUNTER_BITS (COUNTER_BITS)
   ) board_control0 (
      .clk         (clk),
      .reset_b     (reset_b),
      .sw1_1       (sw1_1),
      .sw1_2       (sw1_2),
      .sw2_1       (sw2_1),
      .sw2_2       (sw2_2),
      .sys_reset_b (sys_reset_b),
      .led1        (led1),
      .led2        (led2),
      .led3        (led3),
      .led4        (led4)
   );

   // Chip selects and read data mux
   bus_decode #(
      .RAMSIZE (RAMSIZE)
   ) bus_decode0 (
      .address   (address),
      .ram_dout  (ram_dout),
      .uart_dout (uart_dout),
      .ram_cs_b  (ram_cs_b),
      .uart_cs_b (uart_cs_b),
      .din       (din)
   );

   // Only the low address bits reach the RAM, hence the mirrors
   word_ram #(
      .RAMSIZE (RAMSIZE)
   ) word_ram0 (
      .clk     (clk),
      .cs_b    (ram_cs_b),
      .rnw     (rnw),
      .address (address[RAMSIZE-1:0]),
      .din     (dout),
      .dout    (ram_dout)
   );

   uart_regs #(
      .CLKSPEED (CLKSPEED),
      .BAUD     (BAUD)
   ) uart_regs0 (
      .clk     (clk),
      .reset_b (sys_reset_b),
      .cs_b    (uart_cs_b),
      .rnw     (rnw),
      .a0      (address[0]),
      .din     (dout),
      .dout    (uart_dout),
      .rxd     (rxd),
      .txd     (txd)
   );

endmodule

`default_nettype wire

/* src/board_control.sv */
`timescale 1ns/1ps
`default_nettype none

module board_control #(
   parameter int COUNTER_BITS = 24
)
(
   input  wire  clk,
   input  wire  reset_b,
   input  wire  sw1_1,
   input  wire  sw1_2,
   input  wire  sw2_1,
   input  wire  sw2_2,
   output logic sys_reset_b,
   output logic led1,
   output logic led2,
   output logic led3,
   output logic led4
);

   // Heartbeat, slow enough to see on the board
   logic [COUNTER_BITS-1:0] counter;

   // Reset switch registered onto the clock
   always_ff @(posedge clk)
   begin
      sys_reset_b <= reset_b;
   end

   always_ff @(posedge clk)
   begin
      if (!sys_reset_b)
         counter <= '0;
      else
         counter <= counter + 1'b1;
   end

   // Top four counter bits, each forced on by its switch
   assign led1 = counter[COUNTER_BITS-1] | sw2_1;
   assign led2 = counter[COUNTER_BITS-2] | sw2_2;
   assign led3 = counter[COUNTER_BITS-3] | sw1_1;
   assign led4 = counter[COUNTER_BITS-4] | sw1_2;

endmodule

`default_nettype wire

/* src/uart_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_regs
   import opc_bus_pkg::*;
#(
   parameter int CLKSPEED = 40000000,
   parameter int BAUD     = 115200
)
(
   input  wire   clk,
   input  wire   reset_b,
   input  wire   cs_b,
   input  wire   rnw,
   input  wire   a0,
   input  data_t din,
   output data_t dout,
   input  wire   rxd,
   output logic  txd
);

   logic  tx_start;
   byte_t tx_data;
   logic  tx_busy;
   logic  rx_valid;
   byte_t rx_data;
   logic  rx_full;
   byte_t rx_buf;
   logic  data_wr;
   logic  data_rd;
   logic  busy_flag;

   // Bus accesses to the data register
   assign data_wr = !cs_b && !rnw && a0;
   assign data_rd = !cs_b && rnw && a0;

   // Launch cycle counts as busy too, so polling never misses it
   assign busy_flag = tx_busy || tx_start;

   // Control flags
   always_ff @(posedge clk)
   begin
      if (!reset_b)
      begin
         tx_start <= 1'b0;
         rx_full  <= 1'b0;
      end
      else
      begin
         // One cycle launch, writes while busy are dropped
         tx_start <= data_wr && !busy_flag;
         // New byte beats a clearing read
         if (rx_valid)
            rx_full <= 1'b1;
         else if (data_rd)
            rx_full <= 1'b0;
      end
   end

   // Character registers
   always_ff @(posedge clk)
   begin
      if (data_wr && !busy_flag)
         tx_data <= din[7:0];
      // Unread byte is overwritten
      if (rx_valid)
         rx_buf <= rx_data;
   end

   // Status word or received byte
   always_comb
   begin
      dout = '0;
      if (a0)
         dout[7:0] = rx_buf;
      else
      begin
         dout[UART_STATUS_RX_FULL] = rx_full;
         dout[UART_STATUS_TX_BUSY] = busy_flag;
      end
   end

   uart_tx #(
      .CLKSPEED (CLKSPEED),
      .BAUD     (BAUD)
   ) uart_tx0 (
      .clk      (clk),
      .reset_b  (reset_b),
      .tx_start (tx_start),
      .tx_data  (tx_data),
      .tx_busy  (tx_busy),
      .txd      (txd)
   );

   uart_rx #(
      .CLKSPEED (CLKSPEED),
      .BAUD     (BAUD)
   ) uart_rx0 (
      .clk      (clk),
      .reset_b  (reset_b),
      .rxd      (rxd),
      .rx_valid (rx_valid),
      .rx_data  (rx_data)
   );

endmodule

`default_nettype wire

/* src/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx
   import opc_bus_pkg::*;
#(
   parameter int CLKSPEED = 40000000,
   parameter int BAUD     = 115200
)
(
   input  wire   clk,
   input  wire   reset_b,
   input  wire   rxd,
   output logic  rx_valid,
   output byte_t rx_data
);

   localparam int BIT_PERIOD = CLKSPEED / BAUD;
   localparam int HALF       = BIT_PERIOD / 2;
   localparam int CW         = $clog2(BIT_PERIOD + 1);

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

   rx_state_t     state;
   // Two stage synchronizer plus one bit of history
   logic          rxd_s1;
   logic          rxd_s2;
   logic          rxd_s3;
   logic [CW-1:0] cnt;
   logic [2:0]    bit_idx;
   byte_t         shift;
   logic          centre;

   // Bit centre, counted from the previous centre
   assign centre = (cnt == CW'(BIT_PERIOD - 1));

   always_ff @(posedge clk)
   begin
      if (!reset_b)
      begin
         rxd_s1   <= 1'b1;
         rxd_s2   <= 1'b1;
         rxd_s3   <= 1'b1;
         state    <= RX_IDLE;
         cnt      <= '0;
         bit_idx  <= '0;
         rx_valid <= 1'b0;
      end
      else
      begin
         rxd_s1   <= rxd;
         rxd_s2   <= rxd_s1;
         rxd_s3   <= rxd_s2;
         rx_valid <= 1'b0;
         cnt      <= cnt + 1'b1;
         case (state)
            RX_IDLE:
            begin
               cnt <= '0;
               // High to low marks a start bit
               if (rxd_s3 && !rxd_s2)
                  state <= RX_START;
            end
            RX_START:
            begin
               // Still low half a bit in, else a glitch
               if (cnt == CW'(HALF - 1))
               begin
                  cnt     <= '0;
                  bit_idx <= '0;
                  state   <= rxd_s2 ? RX_IDLE : RX_DATA;
               end
            end
            RX_DATA:
            begin
               if (centre)
               begin
                  cnt     <= '0;
                  bit_idx <= bit_idx + 3'd1;
                  if (bit_idx == 3'd7)
                     state <= RX_STOP;
               end
            end
            default:
            begin
               // Framing error drops the byte
               if (centre)
               begin
                  rx_valid <= rxd_s2;
                  state    <= RX_IDLE;
               end
            end
         endcase
      end
   end

   // Byte assembly, LSB arrives first
   always_ff @(posedge clk)
   begin
      if (state == RX_DATA && centre)
         shift <= {rxd_s2, shift[7:1]};
      if (state == RX_STOP && centre)
         rx_data <= shift;
   end

endmodule

`default_nettype wire

/* src/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx
   import opc_bus_pkg::*;
#(
   parameter int CLKSPEED = 40000000,
   parameter int BAUD     = 115200
)
(
   input  wire   clk,
   input  wire   reset_b,
   input  wire   tx_start,
   input  byte_t tx_data,
   output logic  tx_busy,
   output logic  txd
);

   // Clocks per serial bit
   localparam int BIT_PERIOD = CLKSPEED / BAUD;
   localparam int CW         = $clog2(BIT_PERIOD + 1);

   logic [CW-1:0] period_cnt;
   logic [3:0]    bit_idx;
   // Data bits with the stop bit parked on top
   logic [8:0]    shift;
   logic          period_end;

   assign period_end = (period_cnt == CW'(BIT_PERIOD - 1));

   always_ff @(posedge clk)
   begin
      if (!reset_b)
      begin
         tx_busy    <= 1'b0;
         txd        <= 1'b1;
         period_cnt <= '0;
         bit_idx    <= '0;
      end
      else if (!tx_busy)
      begin
         if (tx_start)
         begin
            // Start bit goes out straight away
            tx_busy    <= 1'b1;
            txd        <= 1'b0;
            period_cnt <= '0;
            bit_idx    <= '0;
         end
      end
      else if (period_end)
      begin
         period_cnt <= '0;
         // Index 9 is the stop bit, frame done after it
         if (bit_idx == 4'd9)
            tx_busy <= 1'b0;
         else
         begin
            txd     <= shift[0];
            bit_idx <= bit_idx + 4'd1;
         end
      end
      else
         period_cnt <= period_cnt + 1'b1;
   end

   // LSB first, ones fill in behind
   always_ff @(posedge clk)
   begin
      if (tx_start && !tx_busy)
         shift <= {1'b1, tx_data};
      else if (tx_busy && period_end)
         shift <= {1'b1, shift[8:1]};
   end

endmodule

`default_nettype wire

/* src/word_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module word_ram
   import opc_bus_pkg::*;
#(
   parameter int RAMSIZE = 12
)
(
   input  wire                clk,
   input  wire                cs_b,
   input  wire                rnw,
   input  wire  [RAMSIZE-1:0] address,
   input  data_t              din,
   output data_t              dout
);

   // 2^RAMSIZE words of storage
   data_t mem [2**RAMSIZE];

   // Falling edge access
   // Read word settles in the second half of the cycle,
   // ready for the processor at the next rising edge
   always_ff @(negedge clk)
   begin
      if (!cs_b)
      begin
         if (rnw)
            dout <= mem[address];
         else
            mem[address] <= din;
      end
   end

endmodule

`default_nettype wire

/* src/bus_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_decode
   import opc_bus_pkg::*;
#(
   parameter int RAMSIZE = 12
)
(
   input  addr_t address,
   input  data_t ram_dout,
   input  data_t uart_dout,
   output logic  ram_cs_b,
   output logic  uart_cs_b,
   output data_t din
);

   logic uart_sel;
   logic ram_sel;
   logic [15-RAMSIZE:0] upper;

   // Address bits above the RAM window
   assign upper = address[15:RAMSIZE];

   // UART pair, bit 0 picks the register
   assign uart_sel = ({address[15:1], 1'b0} == UART_BASE);

   // RAM mirrored at bottom and top of the map
   // UART wins where the two overlap
   assign ram_sel = ((upper == '0) || (&upper)) && !uart_sel;

   assign uart_cs_b = !uart_sel;
   assign ram_cs_b  = !ram_sel;

   // Read data back to the processor
   always_comb
   begin
      if (uart_sel)
         din = uart_dout;
      else if (ram_sel)
         din = ram_dout;
      else
         din = IDLE_DATA;
   end

endmodule

`default_nettype wire

/* src/opc_bus_pkg.sv */
`default_nettype none

package opc_bus_pkg;

   // Processor bus word and word address
   typedef logic [15:0] data_t;
   typedef logic [15:0] addr_t;

   // One serial character
   typedef logic [7:0] byte_t;

   // Even register of the UART pair
   // Status at fe08, data at fe09
   localparam addr_t UART_BASE = 16'hfe08;

   // Bit positions in the UART status word
   localparam int UART_STATUS_RX_FULL = 0;
   localparam int UART_STATUS_TX_BUSY = 1;

   // Returned when nothing is selected
   localparam data_t IDLE_DATA = 16'hffff;

endpackage

`default_nettype wire
